// ==== src/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      byte_en_t;
  typedef logic [6:0]      opcode_t;

  localparam opcode_t op_load    = 7'b0000011;
  localparam opcode_t op_alu_imm = 7'b0010011;
  localparam opcode_t op_auipc   = 7'b0010111;
  localparam opcode_t op_store   = 7'b0100011;
  localparam opcode_t op_alu_reg = 7'b0110011;
  localparam opcode_t op_lui     = 7'b0110111;
  localparam opcode_t op_branch  = 7'b1100011;
  localparam opcode_t op_jalr    = 7'b1100111;
  localparam opcode_t op_jal     = 7'b1101111;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_sltu   = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_sub    = 4'b1000,
    alu_pass_b = 4'b1010,  // lui
    alu_sra    = 4'b1101
  } alu_op_t;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_t;

  typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rs1} src_a_t;
  typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_t;

  typedef enum logic [1:0] {res_alu_out, res_data, res_alu_result} result_sel_t;

  typedef enum logic [1:0] {br_none, br_uncond, br_cond} branch_t;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_mem_read, st_write
  } state_t;

endpackage

// ==== src/ctrl_if.sv ====
interface ctrl_if import rv_pkg::*; ();
  logic        pc_write;
  logic        ir_write;
  logic        adr_sel;     // 0 pc, 1 result
  src_a_t      src_a;
  src_b_t      src_b;
  alu_op_t     alu_op;
  imm_sel_t    imm_sel;
  result_sel_t result_sel;
  logic        reg_write;
  byte_en_t    mem_write;

  word_t       instr;
  logic        alu_zero;
  logic        alu_lt;
  logic        alu_borrow;

  modport ctrl (
    output pc_write, ir_write, adr_sel, src_a, src_b, alu_op, imm_sel, result_sel,
    output reg_write, mem_write,
    input  instr, alu_zero, alu_lt, alu_borrow
  );

  modport dp (
    input  pc_write, ir_write, adr_sel, src_a, src_b, alu_op, imm_sel, result_sel,
    input  reg_write, mem_write,
    output instr, alu_zero, alu_lt, alu_borrow
  );
endinterface

// ==== src/alu.sv ====
module alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   result,
  output logic    zero,
  output logic    lt,
  output logic    borrow
);
  assign lt     = $signed(a) < $signed(b);
  assign borrow = a < b;  // unsigned less-than

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << b[4:0];
      alu_slt:    result = word_t'(lt);
      alu_sltu:   result = word_t'(borrow);
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> b[4:0];
      alu_sra:    result = word_t'($signed(a) >>> b[4:0]);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);
endmodule

// ==== src/register_file.sv ====
module register_file import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  logic      we,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2
);
  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];
endmodule

// ==== src/imm_extend.sv ====
module imm_extend import rv_pkg::*; (
  input  word_t    instr,
  input  imm_sel_t sel,
  output word_t    imm
);
  always_comb begin
    case (sel)
      imm_i: imm = {{20{instr[31]}}, instr[31:20]};
      imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b: begin
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      imm_u: imm = {instr[31:12], 12'b0};
      imm_j: begin
        // 21-bit offset, bit 0 implied
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: imm = '0;
    endcase
  end
endmodule

// ==== src/mc_control.sv ====
module mc_control import rv_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  ctrl_if.ctrl cif
);
  state_t     state;
  state_t     next_state;
  branch_t    branch;
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  logic       taken;

  assign opcode   = cif.instr[6:0];
  assign funct3   = cif.instr[14:12];
  assign funct7_5 = cif.instr[30];

  always_comb begin
    next_state     = st_fetch;
    branch         = br_none;
    cif.ir_write   = 1'b0;
    cif.adr_sel    = 1'b0;
    cif.src_a      = src_a_old_pc;
    cif.src_b      = src_b_imm;
    cif.alu_op     = alu_add;
    cif.imm_sel    = imm_i;
    cif.result_sel = res_alu_out;
    cif.reg_write  = 1'b0;
    cif.mem_write  = '0;

    case (state)
      st_fetch: begin
        cif.ir_write   = 1'b1;
        cif.src_a      = src_a_pc;
        cif.src_b      = src_b_four;
        cif.result_sel = res_alu_result;
        branch         = br_uncond;
        next_state     = st_decode;
      end
      st_decode: begin
        // old pc + imm lands in alu_out for branch, auipc and jal
        case (opcode)
          op_branch: cif.imm_sel = imm_b;
          op_auipc:  cif.imm_sel = imm_u;
          op_jal:    cif.imm_sel = imm_j;
          default:   cif.imm_sel = imm_i;
        endcase
        next_state = st_execute;
      end
      st_execute: begin
        case (opcode)
          op_load: begin
            cif.src_a  = src_a_rs1;
            next_state = st_mem_read;
          end
          op_alu_imm: begin
            cif.src_a  = src_a_rs1;
            cif.alu_op = alu_op_t'({funct7_5 & (funct3 == 3'b101), funct3});  // srai only
            next_state = st_write;
          end
          op_auipc: cif.reg_write = 1'b1;
          op_store: begin
            cif.imm_sel = imm_s;
            cif.src_a   = src_a_rs1;
            next_state  = st_write;
          end
          op_alu_reg: begin
            cif.src_a  = src_a_rs1;
            cif.src_b  = src_b_rs2;
            cif.alu_op = alu_op_t'({funct7_5, funct3});
            next_state = st_write;
          end
          op_lui: begin
            cif.imm_sel = imm_u;
            cif.alu_op  = alu_pass_b;
            next_state  = st_write;
          end
          op_branch: begin
            cif.src_a  = src_a_rs1;
            cif.src_b  = src_b_rs2;
            cif.alu_op = alu_sub;
            branch     = br_cond;  // target already in alu_out
          end
          op_jalr: begin
            cif.src_a      = src_a_rs1;
            cif.result_sel = res_alu_result;
            branch         = br_uncond;
            next_state     = st_write;
          end
          op_jal: begin
            branch     = br_uncond;
            next_state = st_write;
          end
          default: next_state = st_fetch;
        endcase
      end
      st_mem_read: begin
        cif.adr_sel = 1'b1;
        next_state  = st_write;
      end
      st_write: begin
        case (opcode)
          op_load: begin
            cif.result_sel = res_data;
            cif.reg_write  = 1'b1;
          end
          op_alu_imm, op_alu_reg, op_lui: cif.reg_write = 1'b1;
          op_store: begin
            cif.adr_sel = 1'b1;
            case (funct3)
              3'b000:  cif.mem_write = 4'b0001;
              3'b001:  cif.mem_write = 4'b0011;
              3'b010:  cif.mem_write = 4'b1111;
              default: cif.mem_write = 4'b0000;
            endcase
          end
          op_jal, op_jalr: begin
            // link = old pc + 4
            cif.src_b      = src_b_four;
            cif.result_sel = res_alu_result;
            cif.reg_write  = 1'b1;
          end
          default: ;
        endcase
      end
      default: next_state = st_fetch;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  taken = cif.alu_zero;     // beq
      3'b001:  taken = !cif.alu_zero;    // bne
      3'b100:  taken = cif.alu_lt;       // blt
      3'b101:  taken = !cif.alu_lt;      // bge
      3'b110:  taken = cif.alu_borrow;   // bltu
      3'b111:  taken = !cif.alu_borrow;  // bgeu
      default: taken = 1'b0;
    endcase
  end

  assign cif.pc_write = (branch == br_uncond) || ((branch == br_cond) && taken);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_fetch;
    end else begin
      state <= next_state;
    end
  end
endmodule

// ==== src/mc_datapath.sv ====
module mc_datapath import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  ctrl_if.dp       cif,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  output byte_en_t mem_wenable,
  input  word_t    mem_rdata
);
  word_t      pc;
  word_t      old_pc;
  word_t      instr;
  word_t      rs1_buf;
  word_t      rs2_buf;
  word_t      mem_data;
  word_t      alu_out;
  word_t      rd1;
  word_t      rd2;
  word_t      imm;
  word_t      src_a;
  word_t      src_b;
  word_t      alu_result;
  word_t      load_ext;
  word_t      result;
  logic [2:0] funct3;

  assign funct3    = instr[14:12];
  assign cif.instr = instr;

  register_file u_regs (
    .clk  (clk),
    .rst_n(rst_n),
    .ra1  (instr[19:15]),
    .ra2  (instr[24:20]),
    .wa   (instr[11:7]),
    .we   (cif.reg_write),
    .wd   (result),
    .rd1  (rd1),
    .rd2  (rd2)
  );

  imm_extend u_imm (.instr(instr), .sel(cif.imm_sel), .imm(imm));

  alu u_alu (
    .a     (src_a),
    .b     (src_b),
    .op    (cif.alu_op),
    .result(alu_result),
    .zero  (cif.alu_zero),
    .lt    (cif.alu_lt),
    .borrow(cif.alu_borrow)
  );

  always_comb begin
    case (cif.src_a)
      src_a_pc:     src_a = pc;
      src_a_old_pc: src_a = old_pc;
      default:      src_a = rs1_buf;
    endcase
    case (cif.src_b)
      src_b_rs2: src_b = rs2_buf;
      src_b_imm: src_b = imm;
      default:   src_b = word_t'(4);
    endcase
    case (cif.result_sel)
      res_data:       result = load_ext;
      res_alu_result: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  // low byte lanes only
  always_comb begin
    case (funct3)
      3'b000:  load_ext = {{24{mem_data[7]}}, mem_data[7:0]};
      3'b001:  load_ext = {{16{mem_data[15]}}, mem_data[15:0]};
      3'b100:  load_ext = {24'b0, mem_data[7:0]};
      3'b101:  load_ext = {16'b0, mem_data[15:0]};
      default: load_ext = mem_data;  // lw
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (cif.pc_write) begin
      pc <= {result[xlen-1:1], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (cif.ir_write) begin
      old_pc <= pc;
      instr  <= mem_rdata;
    end
    rs1_buf  <= rd1;
    rs2_buf  <= rd2;
    mem_data <= mem_rdata;
    alu_out  <= alu_result;
  end

  assign mem_addr    = cif.adr_sel ? result : pc;
  assign mem_wdata   = rs2_buf;  // unshifted
  assign mem_wenable = cif.mem_write;
endmodule

// ==== src/multi_cycle_cpu.sv ====
module multi_cycle_cpu import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  output byte_en_t mem_wenable,
  input  word_t    mem_rdata
);
  ctrl_if cif ();

  mc_control u_control (
    .clk  (clk),
    .rst_n(rst_n),
    .cif  (cif.ctrl)
  );

  mc_datapath u_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .cif        (cif.dp),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wenable(mem_wenable),
    .mem_rdata  (mem_rdata)
  );
endmodule

// ==== tests/cpu_assert.sv ====
module cpu_assert import rv_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input state_t   state,
  input byte_en_t mem_write,
  input logic     reg_write
);
  int failures = 0;

  a_decode_after_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    state == st_fetch |=> state == st_decode)
    else begin
      failures++;
      $error("decode did not follow fetch");
    end

  // strobes only in the write state
  a_store_in_write: assert property (@(posedge clk) disable iff (!rst_n)
    mem_write != '0 |-> state == st_write)
    else begin
      failures++;
      $error("mem_write active outside the write state");
    end

  a_no_early_reg_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(reg_write && (state == st_fetch || state == st_decode)))
    else begin
      failures++;
      $error("reg_write active in fetch or decode");
    end
endmodule

bind mc_control cpu_assert u_cpu_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .mem_write(cif.mem_write),
  .reg_write(cif.reg_write)
);

// ==== tests/rv_ref_model.svh ====
// instruction-level model, memory indexed by address bits 11 to 2 like the bench
word_t    ref_mem [0:1023];
word_t    ref_regs [0:31];
word_t    exp_addr [$];
word_t    exp_data [$];
byte_en_t exp_be [$];

function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: return (a < b) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic ref_step(inout word_t pc);
  word_t      ins;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      addr;
  word_t      w;
  word_t      res;
  word_t      nxt;
  logic [2:0] f3;
  logic       wr;
  logic       tk;
  byte_en_t   be;
  int         i;
  ins   = ref_mem[pc[11:2]];
  f3    = ins[14:12];
  a     = ref_regs[ins[19:15]];
  b     = ref_regs[ins[24:20]];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_u = {ins[31:12], 12'b0};
  imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  nxt   = pc + 4;
  wr    = 1'b1;
  res   = '0;
  case (ins[6:0])
    op_lui:     res = imm_u;
    op_auipc:   res = pc + imm_u;
    op_alu_reg: res = alu_model(f3, ins[30], a, b);
    op_alu_imm: res = alu_model(f3, ins[30] && (f3 == 3'b101), a, imm_i);
    op_jal: begin
      res = pc + 4;
      nxt = pc + imm_j;
    end
    op_jalr: begin
      res = pc + 4;
      nxt = (a + imm_i) & ~32'd1;
    end
    op_load: begin
      addr = a + imm_i;
      w    = ref_mem[addr[11:2]];  // low lanes of the word
      case (f3)
        3'b000:  res = {{24{w[7]}}, w[7:0]};
        3'b001:  res = {{16{w[15]}}, w[15:0]};
        3'b100:  res = {24'b0, w[7:0]};
        3'b101:  res = {16'b0, w[15:0]};
        default: res = w;
      endcase
    end
    op_store: begin
      wr   = 1'b0;
      addr = a + imm_s;
      be   = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
      exp_addr.push_back(addr);
      exp_data.push_back(b);
      exp_be.push_back(be);
      for (i = 0; i < 4; i++) begin
        if (be[i]) ref_mem[addr[11:2]][8*i +: 8] = b[8*i +: 8];
      end
    end
    op_branch: begin
      wr = 1'b0;
      case (f3)
        3'b000:  tk = (a == b);
        3'b001:  tk = (a != b);
        3'b100:  tk = ($signed(a) < $signed(b));
        3'b101:  tk = ($signed(a) >= $signed(b));
        3'b110:  tk = (a < b);
        3'b111:  tk = (a >= b);
        default: tk = 1'b0;
      endcase
      if (tk) nxt = pc + imm_b;
    end
    default: wr = 1'b0;
  endcase
  if (wr && (ins[11:7] != 5'd0)) ref_regs[ins[11:7]] = res;
  pc = nxt;
endtask

task automatic run_ref_model();
  word_t pc;
  int    steps;
  ref_mem  = mem;
  ref_regs = '{default: '0};
  pc       = '0;
  steps    = 0;
  while ((pc != halt_pc) && (steps < 10000)) begin
    ref_step(pc);
    steps++;
  end
  if (pc != halt_pc) begin
    $display("reference model never reached the final jump");
    errors++;
  end
endtask

// ==== tests/tb_multi_cycle_cpu.sv ====
module tb_multi_cycle_cpu import rv_pkg::*; ();
  logic     clk;
  logic     rst_n;
  word_t    mem_addr;
  word_t    mem_wdata;
  word_t    mem_rdata;
  byte_en_t mem_wenable;

  word_t    mem [0:1023];  // 4 KiB, word index = addr[11:2]
  int       errors;
  word_t    rnd_state;
  word_t    halt_pc;

  `include "rv_ref_model.svh"

  multi_cycle_cpu dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wenable(mem_wenable),
    .mem_rdata  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  assign mem_rdata = mem[mem_addr[11:2]];

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (mem_wenable[i]) mem[mem_addr[11:2]][8*i +: 8] <= mem_wdata[8*i +: 8];
    end
  end

  function automatic word_t next_random();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  function automatic int unsigned uniform(int unsigned n);
    return (next_random() >> 8) % n;
  endfunction

  function automatic reg_addr_t any_reg();
    return reg_addr_t'(uniform(32));
  endfunction

  function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_alu_reg};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store};  // base x0
  endfunction

  function automatic word_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t j_type(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic build_program();
    word_t       w;
    logic [11:0] imm12;
    logic [2:0]  f3;
    logic        alt;
    int unsigned k;
    int unsigned cls;
    for (int a = 0; a < 1024; a++) begin
      mem[a] = next_random();
    end
    for (int i = 0; i < 60; i++) begin
      f3    = 3'(uniform(8));
      alt   = 1'(uniform(2));
      imm12 = 12'(uniform(4096));
      w     = next_random();
      k     = 1 + uniform(4);
      if (i + k > 60) k = 60 - i;  // never skip past the register dump
      cls = (i % 6 == 5) ? 4 : uniform(8);  // regular stores keep gaps short
      case (cls)
        0: mem[i] = r_type((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                           any_reg(), any_reg(), f3, any_reg());
        1: begin
          if (f3 == 3'b001) imm12 = imm12 & 12'h01f;
          if (f3 == 3'b101) imm12 = (imm12 & 12'h01f) | (alt ? 12'h400 : 12'h000);
          mem[i] = i_type(imm12, any_reg(), f3, any_reg(), op_alu_imm);
        end
        2: mem[i] = {w[31:12], any_reg(), alt ? op_lui : op_auipc};
        3: begin
          if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) f3 = 3'b010;
          imm12  = 12'h400 + 12'(4 * uniform(256));
          mem[i] = i_type(imm12, 5'd0, f3, any_reg(), op_load);
        end
        4: mem[i] = s_type(12'h400 + 12'(4 * uniform(256)), any_reg(), 3'(uniform(3)));
        5: begin
          if (f3 == 3'b010 || f3 == 3'b011) f3 = f3 + 3'd2;
          mem[i] = b_type(13'(4 * k), any_reg(), any_reg(), f3);
        end
        6: mem[i] = j_type(21'(4 * k), any_reg());
        default: mem[i] = i_type(12'(4 * (i + k)), 5'd0, 3'b000, any_reg(), op_jalr);
      endcase
    end
    // offsets 0x800 and up sign-extend and wrap onto 0x800 in the array
    for (int r = 1; r < 32; r++) begin
      mem[59 + r] = s_type(12'h800 + 12'(4 * (r - 1)), reg_addr_t'(r), 3'b010);
    end
    mem[91]  = j_type(21'd0, 5'd0);
    halt_pc = 32'd364;
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte_en(string name, byte_en_t got, byte_en_t exp);
    if (got !== exp) begin
      $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_store(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && (cycles < 100)) begin
      @(negedge clk);
      seen = (mem_wenable != '0);
      cycles++;
    end
  endtask

  initial begin
    bit seen;
    bit timed_out;
    int compared;
    rst_n     = 1'b0;
    errors    = 0;
    compared  = 0;
    timed_out = 1'b0;
    rnd_state = 32'd41758;
    build_program();
    run_ref_model();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    while ((exp_addr.size() > 0) && !timed_out) begin
      wait_store(seen);
      if (!seen) begin
        $display("timeout, no store for 100 cycles with %0d stores still expected",
                 exp_addr.size());
        errors++;
        timed_out = 1'b1;
      end else begin
        check_word("mem_addr", mem_addr, exp_addr.pop_front());
        check_word("mem_wdata", mem_wdata, exp_data.pop_front());
        check_byte_en("mem_wenable", mem_wenable, exp_be.pop_front());
        compared++;
      end
    end
    // core now spins on its final jal
    if (!timed_out) begin
      wait_store(seen);
      if (seen) begin
        $display("store to %h arrived with no store left to expect", mem_addr);
        errors++;
      end
    end
    errors += dut.u_control.u_cpu_assert.failures;
    $display("%0d stores compared, %0d assertion failures, %0d errors", compared,
             dut.u_control.u_cpu_assert.failures, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end
endmodule

// ==== build.f ====
+incdir+tests
src/rv_pkg.sv
src/ctrl_if.sv
src/alu.sv
src/register_file.sv
src/imm_extend.sv
src/mc_control.sv
src/mc_datapath.sv
src/multi_cycle_cpu.sv
tests/cpu_assert.sv
tests/tb_multi_cycle_cpu.sv

// ==== Bender.yml ====
package:
  name: multi_cycle_cpu

sources:
  - files:
      - src/rv_pkg.sv
      - src/ctrl_if.sv
      - src/alu.sv
      - src/register_file.sv
      - src/imm_extend.sv
      - src/mc_control.sv
      - src/mc_datapath.sv
      - src/multi_cycle_cpu.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cpu_assert.sv
      - tests/tb_multi_cycle_cpu.sv
